//--- common/mbox_pkg.sv
// Mailbox controller shared definitions
// Widths, register offsets, fabric and SRAM request types, decoded command

package mbox_pkg;

    localparam int ADDR_W      = 16;
    // Word address inside the SRAM window, below the window bit
    localparam int WORD_ADDR_W = ADDR_W - 3;
    // Register page bits above the 4-bit register offset
    localparam int REG_PAGE_W  = ADDR_W - 5;

    typedef logic [31:0] user_t;
    typedef logic [31:0] word_t;

    // Always accepted, whatever the valid user list holds
    localparam user_t DEF_VALID_USER = 32'hFFFF_FFFF;

    //////////////////////////////////////////////////////////////////////
    // Register map
    localparam logic [3:0] OFS_LOCK    = 4'h0;
    localparam logic [3:0] OFS_USER    = 4'h4;
    localparam logic [3:0] OFS_DLEN    = 4'h8;
    localparam logic [3:0] OFS_EXECUTE = 4'hC;

    typedef enum logic [2:0] {
        REG_LOCK    = 3'd0,
        REG_USER    = 3'd1,
        REG_DLEN    = 3'd2,
        REG_EXECUTE = 3'd3,
        REG_NONE    = 3'd7
    } reg_sel_e;

    //////////////////////////////////////////////////////////////////////
    // Fabric byte address, top bit picks the SRAM window
    typedef struct packed {
        logic                  window;
        logic [REG_PAGE_W-1:0] page;
        logic [1:0]            idx;
        logic [1:0]            byte_bits;
    } reg_addr_t;

    typedef struct packed {
        logic                   window;
        logic [WORD_ADDR_W-1:0] word_addr;
        logic [1:0]             byte_bits;
    } sram_addr_t;

    typedef union packed {
        reg_addr_t  reg_view;
        sram_addr_t sram_view;
    } mbox_addr_u;

    //////////////////////////////////////////////////////////////////////
    // Fabric side
    typedef struct packed {
        logic       dv;
        logic       write;
        user_t      user;
        mbox_addr_u addr;
        word_t      wdata;
    } mbox_req_t;

    typedef struct packed {
        logic  valid;
        logic  error;
        word_t rdata;
    } mbox_resp_t;

    // One command per accepted request
    typedef struct packed {
        logic                   csr_rd;
        logic                   csr_wr;
        logic                   sram_rd;
        logic                   sram_wr;
        reg_sel_e               reg_sel;
        logic [WORD_ADDR_W-1:0] word_addr;
        word_t                  wdata;
        user_t                  user;
        logic                   error;
        logic                   soc_lock_try;
    } mbox_cmd_t;

    typedef struct packed {
        logic  lock_held;
        logic  zeroizing;
        logic  execute;
        user_t owner;
        logic  owner_is_root;
    } mbox_state_t;

    typedef struct packed {
        logic                   cs;
        logic                   we;
        logic [WORD_ADDR_W-1:0] addr;
        word_t                  wdata;
    } sram_req_t;

endpackage

//--- flist.f
common/mbox_pkg.sv
src/mbox_decode.sv
mbox_regs/mbox_regs.sv
mbox_regs/mbox_zeroize.sv
src/mbox_result.sv
src/mbox_top.sv
tests/mbox_tb_sram.sv
tests/mbox_tb.sv

//--- mbox_regs/mbox_regs.sv
// Mailbox register set
// Lock, owner, data length and execute flag, SRAM request generation
// and the registered response tag for the result stage

`timescale 1ns/1ps

module mbox_regs #(
    parameter int SRAM_DEPTH = 256
) (
    input  logic                  clk,
    input  logic                  rst_b,
    input  mbox_pkg::mbox_cmd_t   cmd,
    input  logic                  zero_done,
    output mbox_pkg::mbox_state_t state,
    output mbox_pkg::word_t       max_dlen,
    output logic                  mbox_release,
    output mbox_pkg::sram_req_t   regs_sram_req,
    output logic                  tag_valid,
    output logic                  tag_error,
    output logic                  tag_sram_rd,
    output logic                  tag_soc_locked,
    output mbox_pkg::word_t       tag_rdata
);
    import mbox_pkg::*;

    localparam int SRAM_AW = $clog2(SRAM_DEPTH);

    logic  lock_held;
    logic  owner_is_root;
    logic  execute;
    logic  execute_prev;
    user_t owner;
    word_t dlen;
    word_t csr_rdata;
    logic  lock_take;
    logic  dlen_wr;
    logic  exec_wr;

    // Lock stays held through zeroization, so a free lock reads 0
    assign lock_take = cmd.csr_rd && (cmd.reg_sel == REG_LOCK) && !lock_held;
    assign dlen_wr   = cmd.csr_wr && (cmd.reg_sel == REG_DLEN);
    assign exec_wr   = cmd.csr_wr && (cmd.reg_sel == REG_EXECUTE);

    //////////////////////////////////////////////////////////////////////
    // Mailbox state

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            lock_held     <= 1'b0;
            owner_is_root <= 1'b0;
            owner         <= '0;
            execute       <= 1'b0;
            execute_prev  <= 1'b0;
            dlen          <= '0;
            max_dlen      <= '0;
        end else begin
            execute_prev <= execute;
            if (zero_done) begin
                // Release finished, mailbox free again
                lock_held     <= 1'b0;
                owner_is_root <= 1'b0;
                owner         <= '0;
                dlen          <= '0;
                max_dlen      <= '0;
            end else begin
                if (lock_take) begin
                    lock_held     <= 1'b1;
                    owner         <= cmd.user;
                    owner_is_root <= !cmd.soc_lock_try;
                end
                if (dlen_wr) begin
                    dlen <= cmd.wdata;
                    // Running maximum sets the zeroization range
                    if (cmd.wdata > max_dlen) begin
                        max_dlen <= cmd.wdata;
                    end
                end
                if (exec_wr) begin
                    execute <= cmd.wdata[0];
                end
            end
        end
    end

    // Falling edge of execute
    assign mbox_release = execute_prev && !execute;

    always_comb begin
        state               = '0;
        state.lock_held     = lock_held;
        state.execute       = execute;
        state.owner         = owner;
        state.owner_is_root = owner_is_root;
    end

    //////////////////////////////////////////////////////////////////////
    // SRAM request, leaves in the command cycle

    always_comb begin
        regs_sram_req       = '0;
        regs_sram_req.cs    = cmd.sram_rd || cmd.sram_wr;
        regs_sram_req.we    = cmd.sram_wr;
        regs_sram_req.addr  = WORD_ADDR_W'(cmd.word_addr[SRAM_AW-1:0]);
        regs_sram_req.wdata = cmd.wdata;
    end

    //////////////////////////////////////////////////////////////////////
    // Response tag

    always_comb begin
        case (cmd.reg_sel)
            REG_LOCK:    csr_rdata = {31'b0, lock_held};
            REG_USER:    csr_rdata = owner;
            REG_DLEN:    csr_rdata = dlen;
            REG_EXECUTE: csr_rdata = {31'b0, execute};
            default:     csr_rdata = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            tag_valid      <= 1'b0;
            tag_error      <= 1'b0;
            tag_sram_rd    <= 1'b0;
            tag_soc_locked <= 1'b0;
        end else begin
            tag_valid      <= cmd.csr_rd || cmd.csr_wr || cmd.sram_rd || cmd.sram_wr ||
                              cmd.error;
            tag_error      <= cmd.error;
            tag_sram_rd    <= cmd.sram_rd;
            tag_soc_locked <= cmd.soc_lock_try && lock_held && owner_is_root;
        end
    end

    // Zero for writes so the result stage needs no extra select
    always_ff @(posedge clk) begin
        tag_rdata <= cmd.csr_rd ? csr_rdata : '0;
    end

endmodule

//--- mbox_regs/mbox_zeroize.sv
// Mailbox release sequencer
// Writes zero to every SRAM word covered by the maximum data length,
// one word per cycle, then pulses done

`timescale 1ns/1ps

module mbox_zeroize #(
    parameter int SRAM_DEPTH = 256
) (
    input  logic                clk,
    input  logic                rst_b,
    input  logic                mbox_release,
    input  mbox_pkg::word_t     max_dlen,
    input  mbox_pkg::sram_req_t regs_sram_req,
    output mbox_pkg::sram_req_t sram_req,
    output logic                zeroizing,
    output logic                zero_done
);
    import mbox_pkg::*;

    localparam int SRAM_AW = $clog2(SRAM_DEPTH);

    logic [32:0]        num_words;
    logic [SRAM_AW-1:0] last_word;
    logic [SRAM_AW-1:0] end_addr;
    logic [SRAM_AW-1:0] wr_addr;
    logic               active;

    // Bytes rounded up to words, capped at the SRAM size
    always_comb begin
        num_words = ({1'b0, max_dlen} + 33'd3) >> 2;
        if (num_words > 33'(SRAM_DEPTH)) begin
            last_word = SRAM_AW'(SRAM_DEPTH - 1);
        end else begin
            last_word = SRAM_AW'(num_words - 33'd1);
        end
    end

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            active    <= 1'b0;
            zero_done <= 1'b0;
            wr_addr   <= '0;
            end_addr  <= '0;
        end else begin
            zero_done <= 1'b0;
            if (mbox_release) begin
                wr_addr  <= '0;
                end_addr <= last_word;
                // Nothing used, finish straight away
                if (num_words == '0) begin
                    zero_done <= 1'b1;
                end else begin
                    active <= 1'b1;
                end
            end else if (active) begin
                if (wr_addr == end_addr) begin
                    active    <= 1'b0;
                    zero_done <= 1'b1;
                end else begin
                    wr_addr <= wr_addr + 1'b1;
                end
            end
        end
    end

    // Done cycle still counts, the lock clears at its end
    assign zeroizing = active || zero_done;

    always_comb begin
        sram_req = regs_sram_req;
        if (active) begin
            sram_req.cs    = 1'b1;
            sram_req.we    = 1'b1;
            sram_req.addr  = WORD_ADDR_W'(wr_addr);
            sram_req.wdata = '0;
        end
    end

endmodule

//--- run.sh
#!/usr/bin/env bash
# Build the mailbox testbench with Verilator and run it
# Pass or fail is taken from the simulation log

set -e

cd "$(dirname "$0")"

LOG=sim.log
OBJ_DIR=obj_dir

verilator --binary --timing -Wno-fatal \
    -f flist.f \
    --top-module mbox_tb \
    -Mdir "$OBJ_DIR" \
    -o mbox_sim

# The simulator exits non-zero on a failing check, the log decides
"./$OBJ_DIR/mbox_sim" > "$LOG" 2>&1 || true
cat "$LOG"

if grep -qx "Testbench passed" "$LOG"; then
    echo "run.sh: simulation PASS"
else
    echo "run.sh: simulation FAIL, see $LOG"
    exit 1
fi

//--- src/mbox_decode.sv
// Mailbox request decode
// Checks the user and ownership, splits the address into register or SRAM
// access and forms one command per request, all within the request cycle

`timescale 1ns/1ps

module mbox_decode #(
    parameter int SRAM_DEPTH      = 256,
    parameter int NUM_VALID_USERS = 5
) (
    input  mbox_pkg::mbox_req_t                     req,
    input  mbox_pkg::user_t                         root_user,
    input  mbox_pkg::user_t [NUM_VALID_USERS-1:0]   valid_users,
    input  mbox_pkg::mbox_state_t                   state,
    output mbox_pkg::mbox_cmd_t                     cmd
);
    import mbox_pkg::*;

    logic     valid_user;
    logic     is_root;
    logic     is_owner;
    logic     in_sram;
    logic     range_err;
    logic     reg_err;
    logic     err;
    reg_sel_e reg_sel;

    //////////////////////////////////////////////////////////////////////
    // User checks

    // Root and the default user are always valid
    always_comb begin
        valid_user = (req.user == root_user) || (req.user == DEF_VALID_USER);
        for (int i = 0; i < NUM_VALID_USERS; i++) begin
            valid_user |= (req.user == valid_users[i]);
        end
    end

    assign is_root = (req.user == root_user);

    // No owner while the SRAM is being cleared
    assign is_owner = state.lock_held && !state.zeroizing &&
                      ((req.user == state.owner) || is_root);

    //////////////////////////////////////////////////////////////////////
    // Address split

    assign in_sram   = req.addr.sram_view.window;
    assign range_err = (req.addr.sram_view.word_addr >= SRAM_DEPTH);

    // Register view, only page 0 with aligned offsets
    always_comb begin
        reg_sel = REG_NONE;
        if (req.addr.reg_view.page == '0) begin
            case ({req.addr.reg_view.idx, req.addr.reg_view.byte_bits})
                OFS_LOCK:    reg_sel = REG_LOCK;
                OFS_USER:    reg_sel = REG_USER;
                OFS_DLEN:    reg_sel = REG_DLEN;
                OFS_EXECUTE: reg_sel = REG_EXECUTE;
                default:     reg_sel = REG_NONE;
            endcase
        end
    end

    // LOCK and USER are read only, DLEN and EXECUTE writable by the owner
    always_comb begin
        reg_err = (reg_sel == REG_NONE);
        if (req.write) begin
            reg_err |= (reg_sel == REG_LOCK) || (reg_sel == REG_USER);
            reg_err |= ((reg_sel == REG_DLEN) || (reg_sel == REG_EXECUTE)) && !is_owner;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Command

    always_comb begin
        if (!valid_user) begin
            err = 1'b1;
        end else if (in_sram) begin
            err = !is_owner || range_err;
        end else begin
            err = reg_err;
        end
    end

    always_comb begin
        cmd           = '0;
        cmd.reg_sel   = reg_sel;
        cmd.word_addr = req.addr.sram_view.word_addr;
        cmd.wdata     = req.wdata;
        cmd.user      = req.user;
        cmd.error     = req.dv && err;
        if (req.dv && !err) begin
            cmd.csr_rd  = !in_sram && !req.write;
            cmd.csr_wr  = !in_sram && req.write;
            cmd.sram_rd = in_sram && !req.write;
            cmd.sram_wr = in_sram && req.write;
            // Non-root attempt at the lock, flagged for the status pulse
            cmd.soc_lock_try = !in_sram && !req.write && (reg_sel == REG_LOCK) && !is_root;
        end
    end

endmodule

//--- src/mbox_result.sv
// Mailbox response stage
// Registers the fabric response and drives the status outputs

`timescale 1ns/1ps

module mbox_result (
    input  logic                  clk,
    input  logic                  rst_b,
    input  logic                  tag_valid,
    input  logic                  tag_error,
    input  logic                  tag_sram_rd,
    input  logic                  tag_soc_locked,
    input  mbox_pkg::word_t       tag_rdata,
    input  mbox_pkg::word_t       sram_rdata,
    input  mbox_pkg::mbox_state_t state,
    output mbox_pkg::mbox_resp_t  resp,
    output logic                  root_data_available,
    output logic                  soc_data_available,
    output logic                  soc_req_locked
);
    import mbox_pkg::*;

    word_t rdata_sel;

    // SRAM read data arrives in the same cycle as its tag
    // Register data is already zero for writes and errors
    always_comb begin
        if (tag_sram_rd) begin
            rdata_sel = sram_rdata;
        end else begin
            rdata_sel = tag_rdata;
        end
    end

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            resp           <= '0;
            soc_req_locked <= 1'b0;
        end else begin
            resp.valid     <= tag_valid;
            resp.error     <= tag_error;
            resp.rdata     <= rdata_sel;
            // Pulse lines up with the LOCK read response
            soc_req_locked <= tag_soc_locked;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Data available levels by mailbox owner
    assign root_data_available = state.execute && state.owner_is_root;
    assign soc_data_available  = state.execute && !state.owner_is_root;

endmodule

//--- src/mbox_top.sv
// Mailbox controller top level
// One fabric port shares a single SRAM between lock owners, with
// zeroization of the used words when the owner releases the mailbox

`timescale 1ns/1ps

module mbox_top #(
    parameter int SRAM_DEPTH      = 256,
    parameter int NUM_VALID_USERS = 5
) (
    input  logic                                    clk,
    input  logic                                    rst_b,
    input  mbox_pkg::mbox_req_t                     req,
    input  mbox_pkg::user_t                         root_user,
    input  mbox_pkg::user_t [NUM_VALID_USERS-1:0]   valid_users,
    input  mbox_pkg::word_t                         sram_rdata,
    output mbox_pkg::mbox_resp_t                    resp,
    output mbox_pkg::sram_req_t                     sram_req,
    output logic                                    root_data_available,
    output logic                                    soc_data_available,
    output logic                                    soc_req_locked
);
    import mbox_pkg::*;

    mbox_cmd_t   cmd;
    mbox_state_t regs_state;
    mbox_state_t state;
    word_t       max_dlen;
    logic        mbox_release;
    sram_req_t   regs_sram_req;
    logic        zeroizing;
    logic        zero_done;

    // Response tag, one cycle behind the request
    logic        tag_valid;
    logic        tag_error;
    logic        tag_sram_rd;
    logic        tag_soc_locked;
    word_t       tag_rdata;

    // Zeroizing flag is owned by the release sequencer
    always_comb begin
        state           = regs_state;
        state.zeroizing = zeroizing;
    end

    mbox_decode #(
        .SRAM_DEPTH      (SRAM_DEPTH),
        .NUM_VALID_USERS (NUM_VALID_USERS)
    ) mbox_decode_inst (
        .req         (req),
        .root_user   (root_user),
        .valid_users (valid_users),
        .state       (state),
        .cmd         (cmd)
    );

    mbox_regs #(
        .SRAM_DEPTH (SRAM_DEPTH)
    ) mbox_regs_inst (
        .clk            (clk),
        .rst_b          (rst_b),
        .cmd            (cmd),
        .zero_done      (zero_done),
        .state          (regs_state),
        .max_dlen       (max_dlen),
        .mbox_release   (mbox_release),
        .regs_sram_req  (regs_sram_req),
        .tag_valid      (tag_valid),
        .tag_error      (tag_error),
        .tag_sram_rd    (tag_sram_rd),
        .tag_soc_locked (tag_soc_locked),
        .tag_rdata      (tag_rdata)
    );

    mbox_zeroize #(
        .SRAM_DEPTH (SRAM_DEPTH)
    ) mbox_zeroize_inst (
        .clk           (clk),
        .rst_b         (rst_b),
        .mbox_release  (mbox_release),
        .max_dlen      (max_dlen),
        .regs_sram_req (regs_sram_req),
        .sram_req      (sram_req),
        .zeroizing     (zeroizing),
        .zero_done     (zero_done)
    );

    mbox_result mbox_result_inst (
        .clk                 (clk),
        .rst_b               (rst_b),
        .tag_valid           (tag_valid),
        .tag_error           (tag_error),
        .tag_sram_rd         (tag_sram_rd),
        .tag_soc_locked      (tag_soc_locked),
        .tag_rdata           (tag_rdata),
        .sram_rdata          (sram_rdata),
        .state               (state),
        .resp                (resp),
        .root_data_available (root_data_available),
        .soc_data_available  (soc_data_available),
        .soc_req_locked      (soc_req_locked)
    );

endmodule

//--- tests/mbox_cases.txt
# op user addr wdata err rdata root_av soc_av locked, all values in hex
# RAND writes random data, ECHO expects the last data written to that word
# I idles for the count in the wdata column, - marks an unused column
R 22222222 0000 00000000 1 00000000 0 0 0
R ffffffff 0004 00000000 0 00000000 0 0 0
R 10000001 0000 00000000 0 00000000 0 0 0
R 10000002 0000 00000000 0 00000001 0 0 0
R 10000002 0004 00000000 0 10000001 0 0 0
W 10000002 0008 00000010 1 00000000 0 0 0
R 10000002 8000 00000000 1 00000000 0 0 0
W 10000001 0000 00000001 1 00000000 0 0 0
R 10000001 0010 00000000 1 00000000 0 0 0
W 10000001 0008 00000010 0 00000000 0 0 0
W a0a00001 0008 00000008 0 00000000 0 0 0
R 10000001 0008 00000000 0 00000008 0 0 0
W 10000001 8000 RAND     0 00000000 0 0 0
W 10000001 800c RAND     0 00000000 0 0 0
W a0a00001 8010 RAND     0 00000000 0 0 0
R 10000001 8000 00000000 0 ECHO     0 0 0
R a0a00001 800c 00000000 0 ECHO     0 0 0
R 10000001 8010 00000000 0 ECHO     0 0 0
R 10000001 8400 00000000 1 00000000 0 0 0
W 10000001 83fc RAND     0 00000000 0 0 0
R 10000001 83fc 00000000 0 ECHO     0 0 0
W 10000001 000c 00000001 0 00000000 0 1 0
R 10000002 000c 00000000 0 00000001 0 1 0
W 10000001 000c 00000000 0 00000000 0 0 0
I -        -    10       - -        - - -
R 10000002 0000 00000000 0 00000000 0 0 0
R 10000002 8000 00000000 0 00000000 0 0 0
R 10000002 800c 00000000 0 00000000 0 0 0
R 10000002 8010 00000000 0 ECHO     0 0 0
R 10000002 83fc 00000000 0 ECHO     0 0 0
W 10000002 000c 00000001 0 00000000 0 1 0
W 10000002 000c 00000000 0 00000000 0 0 0
I -        -    4        - -        - - -
R a0a00001 0000 00000000 0 00000000 0 0 0
R 10000001 0000 00000000 0 00000001 0 0 1
R ffffffff 0000 00000000 0 00000001 0 0 1
R a0a00001 0000 00000000 0 00000001 0 0 0
W a0a00001 000c 00000001 0 00000000 1 0 0
W 10000001 000c 00000000 1 00000000 1 0 0
W a0a00001 000c 00000000 0 00000000 0 0 0
I -        -    4        - -        - - -
R 10000005 0000 00000000 0 00000000 0 0 0
R 10000005 0004 00000000 0 10000005 0 0 0

//--- tests/mbox_tb.sv
// Mailbox controller testbench
// Replays the cases file against the DUT with one request per cycle and
// checks every response, the status levels, the lock pulse and the SRAM port

`timescale 1ns/1ps

module mbox_tb;
    import mbox_pkg::*;

    localparam int    SRAM_DEPTH      = 256;
    localparam int    NUM_VALID_USERS = 5;
    localparam int    SEED            = 75621;
    localparam string CASES_FILE      = "tests/mbox_cases.txt";

    localparam user_t ROOT_USER = 32'hA0A0_0001;
    localparam user_t [NUM_VALID_USERS-1:0] VALID_USERS = {
        32'h1000_0005, 32'h1000_0004, 32'h1000_0003, 32'h1000_0002, 32'h1000_0001
    };

    // One line of the cases file
    typedef struct packed {
        logic [7:0]        op;
        user_t             user;
        logic [ADDR_W-1:0] addr;
        word_t             wdata;
        logic              wdata_rand;
        logic              err;
        word_t             rdata;
        logic              rdata_echo;
        logic              root_av;
        logic              soc_av;
        logic              locked;
    } case_t;

    // Expected results of one issued request
    typedef struct packed {
        logic [15:0] case_idx;
        logic [31:0] drive_cyc;
        mbox_resp_t  resp;
        logic        root_av;
        logic        soc_av;
        logic        locked;
    } expect_t;

    logic                               clk;
    logic                               rst_b;
    mbox_req_t                          req;
    user_t                              root_user;
    user_t [NUM_VALID_USERS-1:0]        valid_users;
    word_t                              sram_rdata;
    mbox_resp_t                         resp;
    sram_req_t                          sram_req;
    logic                               root_data_available;
    logic                               soc_data_available;
    logic                               soc_req_locked;

    case_t     cases[$];
    expect_t   status_q[$];
    expect_t   resp_q[$];
    word_t     written[int];
    sram_req_t sram_exp;
    logic      sram_exp_valid = 1'b0;
    int        zero_next      = 0;
    int        cyc            = 0;
    int        wd_cycles      = 0;
    int        cycle_limit    = 0;

    mbox_top #(
        .SRAM_DEPTH      (SRAM_DEPTH),
        .NUM_VALID_USERS (NUM_VALID_USERS)
    ) mbox_top_inst (
        .clk                 (clk),
        .rst_b               (rst_b),
        .req                 (req),
        .root_user           (root_user),
        .valid_users         (valid_users),
        .sram_rdata          (sram_rdata),
        .resp                (resp),
        .sram_req            (sram_req),
        .root_data_available (root_data_available),
        .soc_data_available  (soc_data_available),
        .soc_req_locked      (soc_req_locked)
    );

    mbox_tb_sram #(
        .DEPTH (SRAM_DEPTH)
    ) mbox_tb_sram_inst (
        .clk      (clk),
        .sram_req (sram_req),
        .rdata    (sram_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Failure reporting and compares

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_resp(input string name, input mbox_resp_t got,
                              input mbox_resp_t exp, input int idx);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED %s (case %0d): got %h/%h/%h, expected %h/%h/%h",
                                name, idx, got.valid, got.error, got.rdata,
                                exp.valid, exp.error, exp.rdata));
        end
    endtask

    task automatic check_sram(input string name, input sram_req_t got,
                              input sram_req_t exp, input int idx);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED %s (case %0d): got %h, expected %h",
                                name, idx, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp,
                             input int idx);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED %s (case %0d): got %h, expected %h",
                                name, idx, got, exp));
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Cases file

    function automatic word_t parse_hex(input string tok);
        word_t v;
        v = '0;
        void'($sscanf(tok, "%h", v));
        return v;
    endfunction

    task automatic load_cases();
        int    fd;
        int    count;
        int    total_idle;
        string line;
        string tok[9];
        case_t c;
        total_idle = 0;
        fd = $fopen(CASES_FILE, "r");
        if (fd == 0) begin
            abort_run("the cases file could not be opened");
        end
        while ($fgets(line, fd) != 0) begin
            count = $sscanf(line, "%s %s %s %s %s %s %s %s %s",
                            tok[0], tok[1], tok[2], tok[3], tok[4],
                            tok[5], tok[6], tok[7], tok[8]);
            // Blank lines and comments
            if (count < 1 || tok[0].substr(0, 0) == "#") begin
                continue;
            end
            if (count != 9) begin
                abort_run({"a line of the cases file has the wrong column count: ", line});
            end
            c    = '0;
            c.op = tok[0].getc(0);
            if (c.op == "I") begin
                c.wdata    = parse_hex(tok[3]);
                total_idle += int'(c.wdata);
            end else begin
                c.user       = parse_hex(tok[1]);
                c.addr       = ADDR_W'(parse_hex(tok[2]));
                c.wdata_rand = (tok[3] == "RAND");
                c.wdata      = c.wdata_rand ? '0 : parse_hex(tok[3]);
                c.err        = (tok[4] == "1");
                c.rdata_echo = (tok[5] == "ECHO");
                c.rdata      = c.rdata_echo ? '0 : parse_hex(tok[5]);
                c.root_av    = (tok[6] == "1");
                c.soc_av     = (tok[7] == "1");
                c.locked     = (tok[8] == "1");
            end
            cases.push_back(c);
        end
        $fclose(fd);
        cycle_limit = 4 * cases.size() + total_idle + 200;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus and scoreboard

    task automatic drive_case(input int k);
        case_t     c;
        mbox_req_t r;
        expect_t   e;
        int        word;
        c       = cases[k];
        word    = int'(c.addr[ADDR_W-2:2]);
        r       = '0;
        r.dv    = 1'b1;
        r.write = (c.op == "W");
        r.user  = c.user;
        r.addr  = mbox_addr_u'(c.addr);
        r.wdata = c.wdata_rand ? $urandom : c.wdata;

        e             = '0;
        e.case_idx    = 16'(k);
        e.drive_cyc   = 32'(cyc);
        e.resp.valid  = 1'b1;
        e.resp.error  = c.err;
        e.resp.rdata  = c.rdata;
        e.root_av     = c.root_av;
        e.soc_av      = c.soc_av;
        e.locked      = c.locked;
        // Read back whatever this testbench last stored in that word
        if (c.rdata_echo) begin
            if (!written.exists(word)) begin
                abort_run($sformatf("case %0d expects an echo of a word never written", k));
            end else begin
                e.resp.rdata = written[word];
            end
        end
        if (r.write && c.addr[ADDR_W-1] && !c.err) begin
            written[word] = r.wdata;
        end

        // An accepted window access leaves for the SRAM in the request cycle
        sram_exp_valid = c.addr[ADDR_W-1] && !c.err;
        sram_exp       = '0;
        sram_exp.cs    = 1'b1;
        sram_exp.we    = r.write;
        sram_exp.addr  = WORD_ADDR_W'(word);
        sram_exp.wdata = r.wdata;

        req <= r;
        status_q.push_back(e);
        resp_q.push_back(e);
    endtask

    // Status follows the command edge
    // Response follows one edge later
    task automatic check_due();
        expect_t e;
        if (status_q.size() > 0 && status_q[0].drive_cyc == 32'(cyc - 1)) begin
            e = status_q.pop_front();
            check_bit("root_data_available", root_data_available, e.root_av, e.case_idx);
            check_bit("soc_data_available", soc_data_available, e.soc_av, e.case_idx);
        end
        if (resp_q.size() > 0 && resp_q[0].drive_cyc == 32'(cyc - 2)) begin
            e = resp_q.pop_front();
            check_resp("resp", resp, e.resp, e.case_idx);
            check_bit("soc_req_locked", soc_req_locked, e.locked, e.case_idx);
        end else begin
            // Nothing in flight for this edge
            check_bit("resp.valid", resp.valid, 1'b0, -1);
            check_bit("soc_req_locked", soc_req_locked, 1'b0, -1);
        end
    endtask

    // SRAM port carries the accepted access or a release write
    task automatic check_sram_port(input int k);
        sram_req_t e;
        if (sram_exp_valid) begin
            check_sram("sram_req", sram_req, sram_exp, k);
            zero_next = 0;
        end else if (sram_req.cs) begin
            // Release writes zero to consecutive words from word 0
            e      = '0;
            e.cs   = 1'b1;
            e.we   = 1'b1;
            e.addr = WORD_ADDR_W'(zero_next);
            check_sram("sram_req", sram_req, e, k);
            zero_next++;
        end else begin
            zero_next = 0;
        end
    endtask

    task automatic run_cycle(input logic issue, input int k);
        @(posedge clk);
        cyc++;
        sram_exp_valid = 1'b0;
        if (issue) begin
            drive_case(k);
        end else begin
            req <= '0;
        end
        @(negedge clk);
        check_due();
        check_sram_port(k);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence

    initial begin
        req         = '0;
        root_user   = ROOT_USER;
        valid_users = VALID_USERS;
        rst_b       = 1'b0;
        void'($urandom(SEED));
        load_cases();

        repeat (8) @(posedge clk);
        rst_b <= 1'b1;

        foreach (cases[k]) begin
            if (cases[k].op == "I") begin
                // Room for the release sequence to finish
                repeat (int'(cases[k].wdata)) run_cycle(1'b0, k);
            end else begin
                run_cycle(1'b1, k);
            end
        end
        repeat (3) run_cycle(1'b0, 0);

        if (resp_q.size() != 0 || status_q.size() != 0) begin
            abort_run("some responses were still outstanding after the last case");
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

    // Watchdog against the cycle limit from the cases file
    always @(posedge clk) begin
        wd_cycles++;
        if (cycle_limit > 0 && wd_cycles > cycle_limit) begin
            abort_run($sformatf("timeout, the cases did not finish in %0d cycles",
                                cycle_limit));
        end
    end

endmodule

//--- tests/mbox_tb_sram.sv
// Behavioural SRAM for the mailbox testbench
// One-cycle read latency, writes land at the clock edge

`timescale 1ns/1ps

module mbox_tb_sram #(
    parameter int DEPTH = 256
) (
    input  logic                clk,
    input  mbox_pkg::sram_req_t sram_req,
    output mbox_pkg::word_t     rdata
);
    import mbox_pkg::*;

    localparam int AW = $clog2(DEPTH);

    word_t mem [DEPTH];

    // Power-up contents, distinct for every word address
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = 32'hC0DE_0000 ^ (32'(i) * 32'h0001_0001);
        end
    end

    always @(posedge clk) begin
        if (sram_req.cs && sram_req.we) begin
            mem[sram_req.addr[AW-1:0]] <= sram_req.wdata;
        end
        // Read data valid in the cycle after the request
        if (sram_req.cs && !sram_req.we) begin
            rdata <= mem[sram_req.addr[AW-1:0]];
        end
    end

endmodule
